// File: hdl/video_pkg.sv
// ====================
// Shared video types: coordinate, colour channel,
// pattern select and the timing axis state enum
// ====================

package video_pkg;

	// Row or column position inside the active area
	typedef logic [9:0] coord_t;

	// One 8-bit colour channel
	typedef logic [7:0] colour_t;

	// Test pattern select code
	// 0 checkerboard, 1 red ramp, 2 green ramp, 3 solid blue
	typedef logic [1:0] pattern_t;

	// State of one raster axis
	// Both horizontal and vertical machines walk the same sequence
	typedef enum logic [1:0] {
		ACTIVE      = 2'd0,
		FRONT_PORCH = 2'd1,
		SYNC        = 2'd2,
		BACK_PORCH  = 2'd3
	} timing_state_t;

endpackage

// File: hdl/video_timing_gen.sv
// ====================
// Raster timing generator with horizontal and vertical
// state machines and registered sync and blank levels
// ====================

`timescale 1ns/1ps

module video_timing_gen #(
	parameter int ACTIVE_COLS = 16,
	parameter int ACTIVE_ROWS = 8,
	parameter int H_FRONT     = 2,
	parameter int H_SYNC      = 3,
	parameter int H_BACK      = 3,
	parameter int V_FRONT     = 1,
	parameter int V_SYNC      = 2,
	parameter int V_BACK      = 1
) (
	input  logic i_Clk,
	input  logic i_rst_n,
	output logic o_n_hsync,
	output logic o_n_vsync,
	output logic o_hblank,
	output logic o_vblank
);

	import video_pkg::*;

	timing_state_t h_state;
	timing_state_t v_state;
	coord_t        h_count;
	coord_t        v_count;
	logic          h_done;
	logic          v_done;
	logic          line_end;

	// Last count of each horizontal interval
	function automatic coord_t h_last(input timing_state_t s);
		case (s)
			ACTIVE:      return coord_t'(ACTIVE_COLS - 1);
			FRONT_PORCH: return coord_t'(H_FRONT - 1);
			SYNC:        return coord_t'(H_SYNC - 1);
			default:     return coord_t'(H_BACK - 1);
		endcase
	endfunction

	// Last count of each vertical interval, in lines
	function automatic coord_t v_last(input timing_state_t s);
		case (s)
			ACTIVE:      return coord_t'(ACTIVE_ROWS - 1);
			FRONT_PORCH: return coord_t'(V_FRONT - 1);
			SYNC:        return coord_t'(V_SYNC - 1);
			default:     return coord_t'(V_BACK - 1);
		endcase
	endfunction

	// Fixed order active, front porch, sync, back porch, then around again
	function automatic timing_state_t next_state(input timing_state_t s);
		case (s)
			ACTIVE:      return FRONT_PORCH;
			FRONT_PORCH: return SYNC;
			SYNC:        return BACK_PORCH;
			default:     return ACTIVE;
		endcase
	endfunction

	always_comb begin
		h_done   = (h_count == h_last(h_state));
		v_done   = (v_count == v_last(v_state));
		// The vertical axis moves once per line, on the last back porch cycle
		line_end = h_done && (h_state == BACK_PORCH);
	end

	// Horizontal axis
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			h_state <= ACTIVE;
			h_count <= '0;
		end else if (h_done) begin
			h_state <= next_state(h_state);
			h_count <= '0;
		end else begin
			h_count <= h_count + coord_t'(1);
		end
	end

	// Vertical axis, starting in the front porch after reset
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			v_state <= FRONT_PORCH;
			v_count <= '0;
		end else if (line_end) begin
			if (v_done) begin
				v_state <= next_state(v_state);
				v_count <= '0;
			end else begin
				v_count <= v_count + coord_t'(1);
			end
		end
	end

	// Output levels follow the state one cycle later
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			o_n_hsync <= 1'b1;
			o_n_vsync <= 1'b1;
			o_hblank  <= 1'b1;
			o_vblank  <= 1'b1;
		end else begin
			o_n_hsync <= (h_state != SYNC);
			o_n_vsync <= (v_state != SYNC);
			o_hblank  <= (h_state != ACTIVE);
			o_vblank  <= (v_state != ACTIVE);
		end
	end

endmodule

// File: hdl/blanking_to_count.sv
// ====================
// Recovers row and column counters and a lock flag
// from blanking edges, with sync and blank delayed to match
// ====================

`timescale 1ns/1ps

module blanking_to_count #(
	parameter int ACTIVE_COLS = 16,
	parameter int ACTIVE_ROWS = 8
) (
	input  logic              i_Clk,
	input  logic              i_rst_n,
	input  logic              i_n_hsync,
	input  logic              i_n_vsync,
	input  logic              i_hblank,
	input  logic              i_vblank,
	output logic              o_n_hsync,
	output logic              o_n_vsync,
	output logic              o_hblank,
	output logic              o_vblank,
	output logic              o_active,
	output logic              o_frame_start,
	output logic              o_locked,
	output video_pkg::coord_t o_col,
	output video_pkg::coord_t o_row
);

	import video_pkg::*;

	logic   hblank_q;
	logic   vblank_q;
	logic   line_start;
	logic   frame_start;
	logic   active_in;
	coord_t col_cnt;
	coord_t row_cnt;
	coord_t col_cur;
	coord_t row_cur;

	// Falling blank edges, seen against the previous input level
	always_comb begin
		line_start  = hblank_q & ~i_hblank;
		frame_start = vblank_q & ~i_vblank;
		active_in   = ~i_hblank & ~i_vblank;
	end

	// Position of the pixel arriving on this cycle
	always_comb begin
		col_cur = col_cnt;
		row_cur = row_cnt;
		if (frame_start) begin
			col_cur = '0;
			row_cur = '0;
		end else if (line_start) begin
			col_cur = '0;
		end
	end

	// Counters hold through blanking and step on each active pixel
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			hblank_q <= 1'b1;
			vblank_q <= 1'b1;
			col_cnt  <= '0;
			row_cnt  <= '0;
		end else begin
			hblank_q <= i_hblank;
			vblank_q <= i_vblank;
			if (active_in) begin
				if (col_cur == coord_t'(ACTIVE_COLS - 1)) begin
					col_cnt <= '0;
					if (row_cur == coord_t'(ACTIVE_ROWS - 1))
						row_cnt <= '0;
					else
						row_cnt <= row_cur + coord_t'(1);
				end else begin
					col_cnt <= col_cur + coord_t'(1);
					row_cnt <= row_cur;
				end
			end
		end
	end

	// All outputs move together, one cycle behind the inputs
	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			o_n_hsync     <= 1'b1;
			o_n_vsync     <= 1'b1;
			o_hblank      <= 1'b1;
			o_vblank      <= 1'b1;
			o_active      <= 1'b0;
			o_frame_start <= 1'b0;
			o_locked      <= 1'b0;
			o_col         <= '0;
			o_row         <= '0;
		end else begin
			o_n_hsync     <= i_n_hsync;
			o_n_vsync     <= i_n_vsync;
			o_hblank      <= i_hblank;
			o_vblank      <= i_vblank;
			o_active      <= active_in;
			o_frame_start <= frame_start;
			// Sticky once the first frame start has been seen
			o_locked      <= o_locked | o_frame_start;
			o_col         <= active_in ? col_cur : '0;
			o_row         <= active_in ? row_cur : '0;
		end
	end

endmodule

// File: hdl/test_pattern_gen.sv
// ====================
// Test pattern generator: maps row, column and the
// frame-latched select to RGB, with timing delayed alongside
// ====================

`timescale 1ns/1ps

module test_pattern_gen #(
	parameter int ACTIVE_COLS = 16,
	parameter int ACTIVE_ROWS = 8
) (
	input  logic                i_Clk,
	input  logic                i_rst_n,
	input  logic                i_n_hsync,
	input  logic                i_n_vsync,
	input  logic                i_hblank,
	input  logic                i_vblank,
	input  logic                i_active,
	input  logic                i_frame_start,
	input  logic                i_locked,
	input  video_pkg::coord_t   i_col,
	input  video_pkg::coord_t   i_row,
	input  video_pkg::pattern_t i_pattern_sel,
	output logic                o_n_hsync,
	output logic                o_n_vsync,
	output logic                o_hblank,
	output logic                o_vblank,
	output logic                o_active,
	output logic                o_locked,
	output video_pkg::coord_t   o_col,
	output video_pkg::coord_t   o_row,
	output video_pkg::colour_t  o_red,
	output video_pkg::colour_t  o_green,
	output video_pkg::colour_t  o_blue
);

	import video_pkg::*;

	// Checkerboard cells are a quarter of the frame on each axis
	localparam int COL_CELL = ACTIVE_COLS / 4;
	localparam int ROW_CELL = ACTIVE_ROWS / 4;

	pattern_t pattern_q;
	pattern_t pattern_now;
	coord_t   col_cell;
	coord_t   row_cell;
	colour_t  red_d;
	colour_t  green_d;
	colour_t  blue_d;

	always_comb begin
		// The first pixel of a frame already uses the new select
		pattern_now = i_frame_start ? i_pattern_sel : pattern_q;
		col_cell    = i_col / coord_t'(COL_CELL);
		row_cell    = i_row / coord_t'(ROW_CELL);
		red_d       = '0;
		green_d     = '0;
		blue_d      = '0;
		if (i_active) begin
			case (pattern_now)
				2'd0: begin
					if (col_cell[0] != row_cell[0]) begin
						red_d   = 8'hff;
						green_d = 8'hff;
						blue_d  = 8'hff;
					end
				end
				2'd1: red_d = {i_col[3:0], 4'b0000};
				2'd2: green_d = {i_row[2:0], 5'b00000};
				default: blue_d = 8'hff;
			endcase
		end
	end

	always_ff @(posedge i_Clk) begin
		if (!i_rst_n) begin
			pattern_q <= '0;
			o_n_hsync <= 1'b1;
			o_n_vsync <= 1'b1;
			o_hblank  <= 1'b1;
			o_vblank  <= 1'b1;
			o_active  <= 1'b0;
			o_locked  <= 1'b0;
			o_col     <= '0;
			o_row     <= '0;
			o_red     <= '0;
			o_green   <= '0;
			o_blue    <= '0;
		end else begin
			pattern_q <= pattern_now;
			o_n_hsync <= i_n_hsync;
			o_n_vsync <= i_n_vsync;
			o_hblank  <= i_hblank;
			o_vblank  <= i_vblank;
			o_active  <= i_active;
			o_locked  <= i_locked;
			o_col     <= i_col;
			o_row     <= i_row;
			o_red     <= red_d;
			o_green   <= green_d;
			o_blue    <= blue_d;
		end
	end

endmodule

// File: hdl/video_pipeline_top.sv
// ====================
// Video raster pipeline top level: timing generator,
// blanking-to-count recovery and test pattern generator
// ====================

`timescale 1ns/1ps

module video_pipeline_top #(
	parameter int ACTIVE_COLS = 16,
	parameter int ACTIVE_ROWS = 8,
	parameter int H_FRONT     = 2,
	parameter int H_SYNC      = 3,
	parameter int H_BACK      = 3,
	parameter int V_FRONT     = 1,
	parameter int V_SYNC      = 2,
	parameter int V_BACK      = 1
) (
	input  logic                i_Clk,
	input  logic                i_rst_n,
	input  video_pkg::pattern_t i_pattern_sel,
	output logic                o_n_hsync,
	output logic                o_n_vsync,
	output logic                o_hblank,
	output logic                o_vblank,
	output logic                o_active,
	output logic                o_locked,
	output video_pkg::coord_t   o_col,
	output video_pkg::coord_t   o_row,
	output video_pkg::colour_t  o_red,
	output video_pkg::colour_t  o_green,
	output video_pkg::colour_t  o_blue
);

	import video_pkg::*;

	// Raw timing levels
	logic   tg_n_hsync;
	logic   tg_n_vsync;
	logic   tg_hblank;
	logic   tg_vblank;

	// Counter stage outputs, one cycle behind the raw timing
	logic   bc_n_hsync;
	logic   bc_n_vsync;
	logic   bc_hblank;
	logic   bc_vblank;
	logic   bc_active;
	logic   bc_frame_start;
	logic   bc_locked;
	coord_t bc_col;
	coord_t bc_row;

	video_timing_gen #(
		.ACTIVE_COLS (ACTIVE_COLS),
		.ACTIVE_ROWS (ACTIVE_ROWS),
		.H_FRONT     (H_FRONT),
		.H_SYNC      (H_SYNC),
		.H_BACK      (H_BACK),
		.V_FRONT     (V_FRONT),
		.V_SYNC      (V_SYNC),
		.V_BACK      (V_BACK)
	) u_timing (
		.i_Clk     (i_Clk),
		.i_rst_n   (i_rst_n),
		.o_n_hsync (tg_n_hsync),
		.o_n_vsync (tg_n_vsync),
		.o_hblank  (tg_hblank),
		.o_vblank  (tg_vblank)
	);

	blanking_to_count #(
		.ACTIVE_COLS (ACTIVE_COLS),
		.ACTIVE_ROWS (ACTIVE_ROWS)
	) u_count (
		.i_Clk         (i_Clk),
		.i_rst_n       (i_rst_n),
		.i_n_hsync     (tg_n_hsync),
		.i_n_vsync     (tg_n_vsync),
		.i_hblank      (tg_hblank),
		.i_vblank      (tg_vblank),
		.o_n_hsync     (bc_n_hsync),
		.o_n_vsync     (bc_n_vsync),
		.o_hblank      (bc_hblank),
		.o_vblank      (bc_vblank),
		.o_active      (bc_active),
		.o_frame_start (bc_frame_start),
		.o_locked      (bc_locked),
		.o_col         (bc_col),
		.o_row         (bc_row)
	);

	test_pattern_gen #(
		.ACTIVE_COLS (ACTIVE_COLS),
		.ACTIVE_ROWS (ACTIVE_ROWS)
	) u_pattern (
		.i_Clk         (i_Clk),
		.i_rst_n       (i_rst_n),
		.i_n_hsync     (bc_n_hsync),
		.i_n_vsync     (bc_n_vsync),
		.i_hblank      (bc_hblank),
		.i_vblank      (bc_vblank),
		.i_active      (bc_active),
		.i_frame_start (bc_frame_start),
		.i_locked      (bc_locked),
		.i_col         (bc_col),
		.i_row         (bc_row),
		.i_pattern_sel (i_pattern_sel),
		.o_n_hsync     (o_n_hsync),
		.o_n_vsync     (o_n_vsync),
		.o_hblank      (o_hblank),
		.o_vblank      (o_vblank),
		.o_active      (o_active),
		.o_locked      (o_locked),
		.o_col         (o_col),
		.o_row         (o_row),
		.o_red         (o_red),
		.o_green       (o_green),
		.o_blue        (o_blue)
	);

endmodule

// File: testbench/video_pipeline_sva.sv
// ====================
// Concurrent assertions on the pipeline's output timing,
// bound into the top level
// ====================

`timescale 1ns/1ps

module video_pipeline_sva #(
	parameter int H_SYNC = 3
) (
	input logic               i_Clk,
	input logic               i_rst_n,
	input logic               i_n_hsync,
	input logic               i_hblank,
	input logic               i_vblank,
	input logic               i_active,
	input logic               i_locked,
	input video_pkg::colour_t i_red,
	input video_pkg::colour_t i_green,
	input video_pkg::colour_t i_blue
);

	// Cycles spent so far in the current hsync low pulse
	int hsync_low_run;

	always_ff @(posedge i_Clk) begin
		if (!i_rst_n)
			hsync_low_run <= 0;
		else if (!i_n_hsync)
			hsync_low_run <= hsync_low_run + 1;
		else
			hsync_low_run <= 0;
	end

	a_active_unblanked: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		i_active |-> (!i_hblank && !i_vblank))
		else $error("Active asserted while a blank is high");

	a_lock_sticky: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		i_locked |=> i_locked)
		else $error("Lock dropped after it was set");

	a_hsync_not_long: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		!i_n_hsync |-> (hsync_low_run < H_SYNC))
		else $error("Hsync low pulse longer than the sync interval");

	a_hsync_not_short: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		$rose(i_n_hsync) |-> (hsync_low_run == H_SYNC))
		else $error("Hsync low pulse shorter than the sync interval");

	a_black_when_blank: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
		!i_active |-> (i_red == 8'h00 && i_green == 8'h00 && i_blue == 8'h00))
		else $error("Colour outputs not zero outside the active area");

endmodule

bind video_pipeline_top video_pipeline_sva #(
	.H_SYNC (H_SYNC)
) u_video_pipeline_sva (
	.i_Clk     (i_Clk),
	.i_rst_n   (i_rst_n),
	.i_n_hsync (o_n_hsync),
	.i_hblank  (o_hblank),
	.i_vblank  (o_vblank),
	.i_active  (o_active),
	.i_locked  (o_locked),
	.i_red     (o_red),
	.i_green   (o_green),
	.i_blue    (o_blue)
);

// File: testbench/tb_video_pipeline.sv
// ====================
// Testbench for the video pipeline: clock, reset, pattern
// table loop, raster model, compare tasks and timeout
// ====================

`timescale 1ns/1ps

module tb_video_pipeline;

	import video_pkg::*;

	localparam int ACTIVE_COLS    = 16;
	localparam int ACTIVE_ROWS    = 8;
	localparam int H_FRONT        = 2;
	localparam int H_SYNC         = 3;
	localparam int V_FRONT        = 1;
	localparam int V_SYNC         = 2;
	localparam int HSYNC_FIRST    = ACTIVE_COLS + H_FRONT;
	localparam int VSYNC_FIRST    = ACTIVE_ROWS + V_FRONT;
	localparam int LINE_CYCLES    = 24;
	localparam int FRAME_CYCLES   = 288;
	localparam int NUM_ENTRIES    = 5;
	localparam int TIMEOUT_CYCLES = (NUM_ENTRIES + 3) * FRAME_CYCLES + 100;
	localparam int PROBE_COL      = 5;
	localparam int PROBE_ROW      = 1;

	// Select codes, with the colour each one gives at the probe pixel
	pattern_t table_sel   [NUM_ENTRIES] = '{2'd2, 2'd0, 2'd3, 2'd1, 2'd0};
	colour_t  table_red   [NUM_ENTRIES] = '{8'h00, 8'hff, 8'h00, 8'h50, 8'hff};
	colour_t  table_green [NUM_ENTRIES] = '{8'h20, 8'hff, 8'h00, 8'h00, 8'hff};
	colour_t  table_blue  [NUM_ENTRIES] = '{8'h00, 8'hff, 8'hff, 8'h00, 8'hff};

	logic     i_Clk = 1'b0;
	logic     i_rst_n;
	pattern_t i_pattern_sel;
	logic     o_n_hsync;
	logic     o_n_vsync;
	logic     o_hblank;
	logic     o_vblank;
	logic     o_active;
	logic     o_locked;
	coord_t   o_col;
	coord_t   o_row;
	colour_t  o_red;
	colour_t  o_green;
	colour_t  o_blue;

	// Raster model state
	logic     monitor_on = 1'b0;
	logic     prev_hblank = 1'b1;
	logic     prev_vblank = 1'b1;
	logic     prev_hsync = 1'b1;
	logic     prev_vsync = 1'b1;
	logic     line_seen = 1'b0;
	logic     frame_seen = 1'b0;
	logic     lock_exp = 1'b0;
	coord_t   exp_col = '0;
	coord_t   exp_row = '0;
	pattern_t exp_pat = '0;
	pattern_t sel_last_cycle = '0;
	int       line_len = 0;
	int       frame_len = 0;
	int       hs_low = 0;
	int       vs_low = 0;
	int       frames_seen = 0;
	int       applied_count = 0;
	int       applied_last_cycle = 0;
	int       frame_entry = -1;
	int       cycle_count = 0;

	video_pipeline_top u_video_pipeline_top (.*);

	always #20 i_Clk = ~i_Clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_colour(input string name, input colour_t got, input colour_t exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_interval(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_idle();
		check_level("o_n_hsync", o_n_hsync, 1'b1);
		check_level("o_n_vsync", o_n_vsync, 1'b1);
		check_level("o_hblank", o_hblank, 1'b1);
		check_level("o_vblank", o_vblank, 1'b1);
		check_level("o_active", o_active, 1'b0);
		check_level("o_locked", o_locked, 1'b0);
		check_coord("o_col", o_col, '0);
		check_coord("o_row", o_row, '0);
		check_colour("o_red", o_red, '0);
		check_colour("o_green", o_green, '0);
		check_colour("o_blue", o_blue, '0);
	endtask

	// Pixel colour as {red, green, blue} for one select and position
	function automatic logic [23:0] expected_rgb(input pattern_t sel, input coord_t col,
			input coord_t row);
		int          c;
		int          r;
		logic [23:0] rgb;
		c   = int'(col);
		r   = int'(row);
		rgb = 24'h000000;
		case (sel)
			2'd0: begin
				if (((c / (ACTIVE_COLS / 4)) % 2) != ((r / (ACTIVE_ROWS / 4)) % 2))
					rgb = 24'hffffff;
			end
			2'd1: rgb[23:16] = colour_t'((c * 16) % 256);
			2'd2: rgb[15:8] = colour_t'((r * 32) % 256);
			default: rgb[7:0] = 8'hff;
		endcase
		return rgb;
	endfunction

	always @(posedge i_Clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	// Outputs are sampled on the falling edge, half a cycle after they change
	always @(negedge i_Clk) begin : raster_model
		logic        frame_start_now;
		logic        line_start_now;
		logic        active_exp;
		int          line_idx;
		int          pixel_idx;
		logic [23:0] rgb;
		if (monitor_on) begin
			frame_start_now = prev_vblank && !o_vblank;
			line_start_now  = prev_hblank && !o_hblank;
			check_level("o_locked", o_locked, lock_exp);
			if (line_start_now) begin
				if (line_seen)
					check_interval("line length", line_len, LINE_CYCLES);
				line_seen = 1'b1;
				line_len  = 0;
			end
			line_len = line_len + 1;
			if (frame_start_now) begin
				if (frame_seen)
					check_interval("frame length", frame_len, FRAME_CYCLES);
				frame_seen  = 1'b1;
				frames_seen = frames_seen + 1;
				frame_len   = 0;
				// The DUT took the select as it stood before this edge
				exp_pat     = sel_last_cycle;
				frame_entry = applied_last_cycle - 1;
			end
			// Raster position in output cycles from the first active pixel of the frame
			line_idx   = frame_len / LINE_CYCLES;
			pixel_idx  = frame_len % LINE_CYCLES;
			frame_len  = frame_len + 1;
			// Reset leaves the raster in vertical blanking until the first frame start
			active_exp = frame_seen && (line_idx < ACTIVE_ROWS) && (pixel_idx < ACTIVE_COLS);
			check_level("o_active", o_active, active_exp);
			if (frame_seen) begin
				check_level("o_hblank", o_hblank, pixel_idx >= ACTIVE_COLS);
				check_level("o_vblank", o_vblank, line_idx >= ACTIVE_ROWS);
				check_level("o_n_hsync", o_n_hsync, !(pixel_idx >= HSYNC_FIRST &&
					pixel_idx < HSYNC_FIRST + H_SYNC));
				check_level("o_n_vsync", o_n_vsync, !(line_idx >= VSYNC_FIRST &&
					line_idx < VSYNC_FIRST + V_SYNC));
			end
			if (!o_n_hsync)
				hs_low = hs_low + 1;
			else if (!prev_hsync) begin
				check_interval("hsync low width", hs_low, H_SYNC);
				hs_low = 0;
			end
			if (!o_n_vsync)
				vs_low = vs_low + 1;
			else if (!prev_vsync) begin
				check_interval("vsync low width", vs_low, V_SYNC * LINE_CYCLES);
				vs_low = 0;
			end
			if (active_exp) begin
				exp_col = coord_t'(pixel_idx);
				exp_row = coord_t'(line_idx);
				check_coord("o_col", o_col, exp_col);
				check_coord("o_row", o_row, exp_row);
				rgb = expected_rgb(exp_pat, exp_col, exp_row);
				check_colour("o_red", o_red, rgb[23:16]);
				check_colour("o_green", o_green, rgb[15:8]);
				check_colour("o_blue", o_blue, rgb[7:0]);
				if (frame_entry >= 0 && exp_col == coord_t'(PROBE_COL) &&
						exp_row == coord_t'(PROBE_ROW)) begin
					check_colour("probe o_red", o_red, table_red[frame_entry]);
					check_colour("probe o_green", o_green, table_green[frame_entry]);
					check_colour("probe o_blue", o_blue, table_blue[frame_entry]);
				end
			end else begin
				check_coord("o_col", o_col, '0);
				check_coord("o_row", o_row, '0);
				check_colour("o_red", o_red, '0);
				check_colour("o_green", o_green, '0);
				check_colour("o_blue", o_blue, '0);
			end
			prev_hblank        = o_hblank;
			prev_vblank        = o_vblank;
			prev_hsync         = o_n_hsync;
			prev_vsync         = o_n_vsync;
			sel_last_cycle     = i_pattern_sel;
			applied_last_cycle = applied_count;
			// Lock follows the first frame start by one cycle
			if (frame_start_now)
				lock_exp = 1'b1;
		end
	end

	initial begin
		int unsigned seed_val;
		int          gap;
		seed_val      = $urandom(32'hf46e_9308);
		i_rst_n       = 1'b0;
		i_pattern_sel = '0;
		repeat (4) begin
			@(posedge i_Clk);
			@(negedge i_Clk);
			check_idle();
		end
		@(posedge i_Clk);
		i_rst_n <= 1'b1;
		// The pipeline still holds reset values for two edges after release
		repeat (2) begin
			@(negedge i_Clk);
			check_idle();
		end
		@(posedge i_Clk);
		monitor_on = 1'b1;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			wait (frames_seen >= i + 1);
			gap = 8 + int'($urandom % 240);
			repeat (gap) @(posedge i_Clk);
			i_pattern_sel <= table_sel[i];
			applied_count = i + 1;
		end
		// One frame for the last select to take effect and one more to close it
		wait (frames_seen >= NUM_ENTRIES + 2);
		$display("Checked %0d full frames", frames_seen - 1);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: src.f
hdl/video_pkg.sv
hdl/video_timing_gen.sv
hdl/blanking_to_count.sv
hdl/test_pattern_gen.sv
hdl/video_pipeline_top.sv
testbench/video_pipeline_sva.sv
testbench/tb_video_pipeline.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the video pipeline testbench with Verilator, runs it and checks the log

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --assert -j 0 --top-module tb_video_pipeline -Mdir obj_dir -f src.f \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_video_pipeline > "$LOG" 2>&1 \
	|| echo "Simulator returned a nonzero status" >> "$LOG"

cat "$LOG"

grep -q "=== FAIL ===" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "nonzero status" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" "$LOG" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
